//--- cache_ctrl.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_way_ram.sv
hdl/cache_hit_lru.sv
hdl/cache_fsm.sv
hdl/cache_ctrl.sv
sim/cache_assertions.sv
sim/cache_tb.sv

//--- hdl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address and data sizes
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// line geometry, four words per line
`define CACHE_LINE_WORDS 4
`define CACHE_OFFSET_W 2

// 16 sets, two ways each
`define CACHE_SETS 16
`define CACHE_INDEX_W 4

// tag is what is left above index, word offset and byte bits
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W - 2)

`endif

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
	import cache_pkg::*;
(
	input  logic  clk,
	input  logic  reset,

	input  logic  req_valid,
	output logic  req_ready,
	input  logic  req_write,
	input  addr_t req_addr,
	input  word_t req_wdata,
	output logic  resp_valid,
	output word_t resp_rdata,

	output logic  mem_req_valid,
	input  logic  mem_req_ready,
	output logic  mem_write,
	output addr_t mem_addr,
	output logic  mem_wvalid,
	input  logic  mem_wready,
	output word_t mem_wdata,
	input  logic  mem_rvalid,
	input  word_t mem_rdata
);

	index_t ram_index;
	logic tag_we_0;
	logic tag_we_1;
	logic line_we_0;
	logic line_we_1;
	tag_entry_t tag_wdata;
	line_t line_wdata;
	tag_entry_t entry_0;
	tag_entry_t entry_1;
	line_t line_0;
	line_t line_1;

	logic hit;
	logic hit_way;
	logic victim_way;
	word_t hit_word;
	logic lru_touch;
	logic touch_way;
	offset_t req_offset;
	tag_t req_tag;

	// tag and data arrays share the set index
	cache_way_ram #(.entry_t(tag_entry_t)) tag_ram_0 (
		.clk(clk), .index(ram_index), .we(tag_we_0), .wdata(tag_wdata), .rdata(entry_0)
	);
	cache_way_ram #(.entry_t(tag_entry_t)) tag_ram_1 (
		.clk(clk), .index(ram_index), .we(tag_we_1), .wdata(tag_wdata), .rdata(entry_1)
	);
	cache_way_ram #(.entry_t(line_t)) line_ram_0 (
		.clk(clk), .index(ram_index), .we(line_we_0), .wdata(line_wdata), .rdata(line_0)
	);
	cache_way_ram #(.entry_t(line_t)) line_ram_1 (
		.clk(clk), .index(ram_index), .we(line_we_1), .wdata(line_wdata), .rdata(line_1)
	);

	cache_hit_lru hit_lru (
		.clk(clk), .reset(reset),
		.index(ram_index), .offset(req_offset), .tag(req_tag),
		.entry_0(entry_0), .entry_1(entry_1), .line_0(line_0), .line_1(line_1),
		.lru_touch(lru_touch), .touch_way(touch_way),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way), .hit_word(hit_word)
	);

	cache_fsm fsm (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wvalid(mem_wvalid), .mem_wready(mem_wready), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
		.ram_index(ram_index),
		.tag_we_0(tag_we_0), .tag_we_1(tag_we_1),
		.line_we_0(line_we_0), .line_we_1(line_we_1),
		.tag_wdata(tag_wdata), .line_wdata(line_wdata),
		.entry_0(entry_0), .entry_1(entry_1), .line_0(line_0), .line_1(line_1),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way), .hit_word(hit_word),
		.lru_touch(lru_touch), .touch_way(touch_way),
		.req_offset(req_offset), .req_tag(req_tag)
	);

endmodule

`default_nettype wire

//--- hdl/cache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_fsm
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	// processor side
	input  logic       req_valid,
	output logic       req_ready,
	input  logic       req_write,
	input  addr_t      req_addr,
	input  word_t      req_wdata,
	output logic       resp_valid,
	output word_t      resp_rdata,

	// memory side
	output logic       mem_req_valid,
	input  logic       mem_req_ready,
	output logic       mem_write,
	output addr_t      mem_addr,
	output logic       mem_wvalid,
	input  logic       mem_wready,
	output word_t      mem_wdata,
	input  logic       mem_rvalid,
	input  word_t      mem_rdata,

	// way rams
	output index_t     ram_index,
	output logic       tag_we_0,
	output logic       tag_we_1,
	output logic       line_we_0,
	output logic       line_we_1,
	output tag_entry_t tag_wdata,
	output line_t      line_wdata,
	input  tag_entry_t entry_0,
	input  tag_entry_t entry_1,
	input  line_t      line_0,
	input  line_t      line_1,

	// lookup results and lru update
	input  logic       hit,
	input  logic       hit_way,
	input  logic       victim_way,
	input  word_t      hit_word,
	output logic       lru_touch,
	output logic       touch_way,
	output offset_t    req_offset,
	output tag_t       req_tag
);

	typedef enum logic [2:0] {
		st_invalidate,
		st_idle,
		st_lookup,
		st_wb_req,
		st_wb_data,
		st_fill_req,
		st_fill_data,
		st_refresh
	} state_t;

	state_t state;
	index_t inv_cnt;	// set being cleared after reset
	offset_t beat;	// burst word counter, wraps after the last beat

	// latched request
	addr_t addr_q;
	word_t wdata_q;
	logic write_q;

	// victim copy for the write-back burst
	logic vway;
	tag_t vtag;
	line_t vline;
	line_t fill_buf;

	tag_entry_t ventry;
	line_t hit_line;
	line_t merge_line;
	line_t fill_line;
	logic victim_dirty;
	logic last_fill;

	assign req_tag = addr_tag(addr_q);
	assign req_offset = addr_offset(addr_q);
	assign req_ready = (state == st_idle);

	assign ventry = victim_way ? entry_1 : entry_0;
	assign victim_dirty = ventry.valid && ventry.dirty;
	assign hit_line = hit_way ? line_1 : line_0;

	assign last_fill = (state == st_fill_data) && mem_rvalid &&
		(beat == offset_t'(`CACHE_LINE_WORDS - 1));

	assign mem_req_valid = (state == st_wb_req) || (state == st_fill_req);
	assign mem_write = (state == st_wb_req);
	assign mem_addr = (state == st_wb_req) ?
		{vtag, addr_index(addr_q), {(`CACHE_OFFSET_W + 2){1'b0}}} :
		{req_tag, addr_index(addr_q), {(`CACHE_OFFSET_W + 2){1'b0}}};
	assign mem_wvalid = (state == st_wb_data);
	assign mem_wdata = vline[beat];

	assign lru_touch = (state == st_lookup) && hit;
	assign touch_way = hit_way;

	always_comb begin
		merge_line = hit_line;
		merge_line[req_offset] = wdata_q;
		fill_line = fill_buf;
		fill_line[`CACHE_LINE_WORDS-1] = mem_rdata;	// last beat goes straight in
	end

	always_comb begin
		case (state)
			st_invalidate: ram_index = inv_cnt;
			st_idle:       ram_index = addr_index(req_addr);	// read ahead of acceptance
			default:       ram_index = addr_index(addr_q);
		endcase

		tag_we_0 = 1'b0;
		tag_we_1 = 1'b0;
		line_we_0 = 1'b0;
		line_we_1 = 1'b0;
		tag_wdata = '0;
		line_wdata = fill_line;

		if (state == st_invalidate) begin
			tag_we_0 = 1'b1;
			tag_we_1 = 1'b1;
		end else if ((state == st_lookup) && hit && write_q) begin
			// write hit, merge the word and mark dirty
			tag_wdata.valid = 1'b1;
			tag_wdata.dirty = 1'b1;
			tag_wdata.tag = req_tag;
			line_wdata = merge_line;
			tag_we_0 = !hit_way;
			tag_we_1 = hit_way;
			line_we_0 = !hit_way;
			line_we_1 = hit_way;
		end else if (last_fill) begin
			tag_wdata.valid = 1'b1;
			tag_wdata.tag = req_tag;	// clean line
			tag_we_0 = !vway;
			tag_we_1 = vway;
			line_we_0 = !vway;
			line_we_1 = vway;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_invalidate;
			inv_cnt <= '0;
			beat <= '0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				st_invalidate: begin
					inv_cnt <= inv_cnt + 1'b1;
					if (inv_cnt == index_t'(`CACHE_SETS - 1)) begin
						state <= st_idle;
					end
				end
				st_idle: begin
					if (req_valid) begin
						state <= st_lookup;
					end
				end
				st_lookup: begin
					if (hit) begin
						resp_valid <= 1'b1;
						state <= st_idle;
					end else if (victim_dirty) begin
						state <= st_wb_req;
					end else begin
						state <= st_fill_req;
					end
				end
				st_wb_req: begin
					if (mem_req_ready) begin
						state <= st_wb_data;
					end
				end
				st_wb_data: begin
					if (mem_wready) begin
						beat <= beat + 1'b1;
						if (beat == offset_t'(`CACHE_LINE_WORDS - 1)) begin
							state <= st_fill_req;
						end
					end
				end
				st_fill_req: begin
					if (mem_req_ready) begin
						state <= st_fill_data;
					end
				end
				st_fill_data: begin
					if (mem_rvalid) begin
						beat <= beat + 1'b1;
					end
					if (last_fill) begin
						state <= st_refresh;
					end
				end
				st_refresh: state <= st_lookup;	// ram sees the new line next cycle
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_idle) && req_valid) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			write_q <= req_write;
		end
		if (state == st_lookup) begin
			resp_rdata <= hit_word;
			if (!hit) begin
				vway <= victim_way;
				vtag <= ventry.tag;
				vline <= victim_way ? line_1 : line_0;
			end
		end
		if ((state == st_fill_data) && mem_rvalid) begin
			fill_buf[beat] <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_hit_lru.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_hit_lru
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	input  index_t     index,
	input  offset_t    offset,
	input  tag_t       tag,

	input  tag_entry_t entry_0,
	input  tag_entry_t entry_1,
	input  line_t      line_0,
	input  line_t      line_1,

	input  logic       lru_touch,
	input  logic       touch_way,

	output logic       hit,
	output logic       hit_way,
	output logic       victim_way,
	output word_t      hit_word
);

	logic [`CACHE_SETS-1:0] lru;	// names the least recently used way
	logic hit_0;
	logic hit_1;
	line_t hit_line;

	assign hit_0 = entry_0.valid && (entry_0.tag == tag);
	assign hit_1 = entry_1.valid && (entry_1.tag == tag);
	assign hit = hit_0 | hit_1;
	assign hit_way = hit_1;	// both can't match

	assign hit_line = hit_way ? line_1 : line_0;
	assign hit_word = hit_line[offset];

	// fill an empty way before evicting anything
	always_comb begin
		if (!entry_0.valid) begin
			victim_way = 1'b0;
		end else if (!entry_1.valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru[index];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lru <= '0;
		end else if (lru_touch) begin
			lru[index] <= ~touch_way;	// the other way is now the older one
		end
	end

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef word_t [`CACHE_LINE_WORDS-1:0] line_t;	// word 0 in the low bits
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;

	// payload of the tag rams
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} tag_entry_t;

	// address fields, the two byte bits are dropped
	function automatic tag_t addr_tag(input addr_t addr);
		return addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	endfunction

	function automatic index_t addr_index(input addr_t addr);
		return addr[`CACHE_OFFSET_W+2 +: `CACHE_INDEX_W];
	endfunction

	function automatic offset_t addr_offset(input addr_t addr);
		return addr[2 +: `CACHE_OFFSET_W];
	endfunction

endpackage

`default_nettype wire

//--- hdl/cache_way_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

// one way of tag or data storage, single port
module cache_way_ram
	import cache_pkg::*;
#(
	parameter type entry_t = logic
) (
	input  logic   clk,
	input  index_t index,
	input  logic   we,
	input  entry_t wdata,
	output entry_t rdata
);

	entry_t mem [`CACHE_SETS];

	// read returns the old contents when written in the same cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end
		rdata <= mem[index];	// registered read
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run, the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f cache_ctrl.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim || exit 1

//--- sim/cache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assertions
	import cache_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  req_valid,
	input logic  req_ready,
	input logic  resp_valid,
	input logic  mem_req_valid,
	input logic  mem_req_ready,
	input logic  mem_write,
	input addr_t mem_addr,
	input logic  mem_wvalid,
	input logic  mem_wready,
	input word_t mem_wdata
);

	logic busy;	// a request is accepted and has not been answered yet

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
		end else if (req_valid && req_ready) begin
			busy <= 1'b1;
		end else if (resp_valid) begin
			busy <= 1'b0;
		end
	end

	mem_req_hold: assert property (@(posedge clk) disable iff (!reset)
		mem_req_valid && !mem_req_ready |=>
		mem_req_valid && $stable(mem_write) && $stable(mem_addr))
		else $error("memory request dropped or changed before mem_req_ready");

	mem_w_hold: assert property (@(posedge clk) disable iff (!reset)
		mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_wdata))
		else $error("write-back beat dropped or changed before mem_wready");

	resp_pulse: assert property (@(posedge clk) disable iff (!reset)
		resp_valid |=> !resp_valid)
		else $error("resp_valid high for two cycles in a row");

	ready_low: assert property (@(posedge clk) disable iff (!reset)
		busy |-> (!req_ready || resp_valid))
		else $error("req_ready high while a request is in flight");

endmodule

`default_nettype wire

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb;
	import cache_pkg::*;

	localparam int n_requests = 2000;
	localparam int cycle_limit = n_requests * 200;
	localparam int mem_words = 256;	// 4 tags x 16 sets x 4 words

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	logic req_write;
	addr_t req_addr;
	word_t req_wdata;
	logic resp_valid;
	word_t resp_rdata;
	logic mem_req_valid;
	logic mem_req_ready;
	logic mem_write;
	addr_t mem_addr;
	logic mem_wvalid;
	logic mem_wready;
	word_t mem_wdata;
	logic mem_rvalid;
	word_t mem_rdata;

	integer seed = 94;
	int cycles = 0;
	int error_count = 0;
	logic outstanding = 1'b0;

	word_t mem_array [mem_words];	// memory model
	word_t ref_mem [mem_words];	// contents as the CPU sees them
	logic m_valid [2][`CACHE_SETS];
	logic m_dirty [2][`CACHE_SETS];
	logic [`CACHE_TAG_W-1:0] m_tag [2][`CACHE_SETS];
	logic m_lru [`CACHE_SETS];

	// memory traffic expected for the current request
	logic exp_wb = 1'b0;
	logic exp_rd = 1'b0;
	addr_t exp_wb_addr;
	addr_t exp_rd_addr;
	word_t exp_wb_line [4];

	cache_ctrl UUT (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.resp_valid(resp_valid), .resp_rdata(resp_rdata),
		.mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wvalid(mem_wvalid), .mem_wready(mem_wready), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
	);

	bind cache_ctrl cache_assertions assertions (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
		.resp_valid(resp_valid), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wvalid(mem_wvalid), .mem_wready(mem_wready), .mem_wdata(mem_wdata)
	);

	function automatic word_t init_word(input int unsigned a);
		return (a * 32'h9e3779b9) ^ 32'h5a5a0000 ^ {a[7:0], 24'h0};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "check failed");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Errors found");
		$fatal(1, "timeout, the DUT stopped making progress");
	end

	// a response with nothing in flight is an error
	initial begin : stray_resp
		forever begin
			@(negedge clk);
			if (resp_valid) compare("resp_valid without request", outstanding, 1'b1);
		end
	end

	// handshakes are seen at the negedge and complete on the next rising edge
	initial begin : memory_model
		logic [7:0] wb_base;
		logic [7:0] rd_base;
		int wb_beat;
		int rd_beat;
		logic rd_busy;
		wb_base = '0;
		rd_base = '0;
		wb_beat = 4;
		rd_beat = 0;
		rd_busy = 1'b0;
		mem_req_ready = 1'b0;
		mem_wready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (mem_req_valid && mem_req_ready) begin
				compare("mem_write", mem_write, exp_wb);	// write-back goes first
				if (mem_write) begin
					compare("mem_addr", mem_addr, exp_wb_addr);
					exp_wb = 1'b0;
					wb_base = mem_addr[9:2];
					wb_beat = 0;
				end else begin
					compare("read request expected", 1'b1, exp_rd);
					compare("mem_addr", mem_addr, exp_rd_addr);
					exp_rd = 1'b0;
					rd_base = mem_addr[9:2];
					rd_beat = 0;
					rd_busy = 1'b1;
				end
			end
			if (mem_wvalid && mem_wready) begin
				compare("write-back beat in burst", wb_beat < 4, 1'b1);
				compare("mem_wdata", mem_wdata, exp_wb_line[wb_beat]);
				mem_array[wb_base + wb_beat] = mem_wdata;
				wb_beat++;
			end
			if (mem_rvalid) begin
				rd_beat++;
				if (rd_beat == 4) rd_busy = 1'b0;
			end
			@(posedge clk);
			#1;
			mem_req_ready = ($random(seed) & 3) != 0;
			mem_wready = ($random(seed) & 3) != 0;
			mem_rvalid = rd_busy && (($random(seed) & 3) != 0);
			mem_rdata = rd_busy ? mem_array[rd_base + rd_beat] : '0;
		end
	end

	initial begin : stimulus
		int gap;
		int lat;
		logic [1:0] tsel;
		logic [3:0] set;
		logic [1:0] off;
		logic wr;
		word_t wd;
		addr_t a;
		logic [7:0] widx;
		logic hit_exp;
		logic way;
		logic vict;
		reset = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		for (int k = 0; k < mem_words; k++) begin
			mem_array[k] = init_word(k * 4);
			ref_mem[k] = init_word(k * 4);
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			m_valid[0][s] = 1'b0;
			m_valid[1][s] = 1'b0;
			m_dirty[0][s] = 1'b0;
			m_dirty[1][s] = 1'b0;
			m_lru[s] = 1'b0;
		end
		@(negedge clk);
		compare("req_ready", req_ready, 1'b0);
		compare("resp_valid", resp_valid, 1'b0);
		compare("mem_req_valid", mem_req_valid, 1'b0);
		compare("mem_wvalid", mem_wvalid, 1'b0);
		@(posedge clk);
		#1;
		reset = 1'b1;
		lat = 0;
		while (!req_ready) begin
			@(negedge clk);
			lat++;
			if (lat > `CACHE_SETS + 2) compare("req_ready after reset", req_ready, 1'b1);
		end
		@(posedge clk);
		#1;
		for (int n = 0; n < n_requests; n++) begin
			gap = $random(seed) & 3;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			tsel = $random(seed);
			set = $random(seed);
			off = $random(seed);
			wr = $random(seed);
			wd = $random(seed);
			a = {22'b0, tsel, set, off, 2'b00};
			widx = a[9:2];
			// predict hit or the victim and its memory traffic
			hit_exp = 1'b0;
			way = 1'b0;
			for (int w = 0; w < 2; w++) begin
				if (m_valid[w][set] && m_tag[w][set] == a[31:8]) begin
					hit_exp = 1'b1;
					way = w[0];
				end
			end
			if (!hit_exp) begin
				vict = !m_valid[0][set] ? 1'b0 : (!m_valid[1][set] ? 1'b1 : m_lru[set]);
				if (m_valid[vict][set] && m_dirty[vict][set]) begin
					exp_wb_addr = {m_tag[vict][set], set, 4'b0000};
					for (int k = 0; k < 4; k++)
						exp_wb_line[k] = ref_mem[{m_tag[vict][set][1:0], set, k[1:0]}];
					exp_wb = 1'b1;
				end
				exp_rd_addr = {a[31:4], 4'b0000};
				exp_rd = 1'b1;
				way = vict;
			end
			req_valid = 1'b1;
			req_write = wr;
			req_addr = a;
			req_wdata = wd;
			do @(negedge clk); while (!req_ready);
			@(posedge clk);
			#1;
			req_valid = 1'b0;
			outstanding = 1'b1;
			lat = 0;
			do begin
				@(negedge clk);
				lat++;
			end while (!resp_valid);
			if (hit_exp) compare("hit latency", lat, 2);
			compare("write-back still pending", exp_wb, 1'b0);
			compare("fill read still pending", exp_rd, 1'b0);
			if (!wr) compare("resp_rdata", resp_rdata, ref_mem[widx]);
			if (wr) ref_mem[widx] = wd;
			m_valid[way][set] = 1'b1;
			m_tag[way][set] = a[31:8];
			m_dirty[way][set] = hit_exp ? (m_dirty[way][set] | wr) : wr;
			m_lru[set] = ~way;
			@(posedge clk);
			#1;
			outstanding = 1'b0;
		end
		if (error_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire
